// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  byte_sel_t;
  typedef logic [6:0]  opcode_t;

  // base opcodes of the supported subset
  localparam opcode_t op_imm   = 7'b001_0011;
  localparam opcode_t op_lui   = 7'b011_0111;
  localparam opcode_t op_auipc = 7'b001_0111;
  localparam opcode_t op_jal   = 7'b110_1111;
  localparam opcode_t op_jalr  = 7'b110_0111;
  localparam opcode_t op_load  = 7'b000_0011;
  localparam opcode_t op_store = 7'b010_0011;

  typedef enum logic {
    src_rs1,
    src_pc
  } src_a_e;

  typedef enum logic [1:0] {
    wb_sum,  // adder result
    wb_pc4,  // link address
    wb_load
  } wb_src_e;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    funct3_t   funct3;    // access width and sign for loads and stores
    word_t     imm;
    src_a_e    src_a;
    wb_src_e   wb_src;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      jump;
  } ctrl_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    word_t     adr;
    word_t     dat;
    byte_sel_t sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  typedef enum logic {
    lsu_idle,
    lsu_bus
  } lsu_state_e;

endpackage

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_pkg::word_t inst,
  output rv_pkg::ctrl_t ctrl
);

  rv_pkg::opcode_t opcode;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;

  assign opcode = inst[6:0];

  // sign-extended immediates of each format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl           = '0;  // unknown opcode falls through as a no-op
    ctrl.rs1       = inst[19:15];
    ctrl.rs2       = inst[24:20];
    ctrl.rd        = inst[11:7];
    ctrl.funct3    = inst[14:12];
    ctrl.imm       = imm_i;
    ctrl.src_a     = rv_pkg::src_rs1;
    ctrl.wb_src    = rv_pkg::wb_sum;

    case (opcode)
      rv_pkg::op_imm: begin
        // only addi is kept, other alu immediates retire without effect
        ctrl.reg_write = (inst[14:12] == 3'b000);
      end
      rv_pkg::op_lui: begin
        ctrl.rs1       = '0;  // x0 plus the upper immediate
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::op_auipc: begin
        ctrl.src_a     = rv_pkg::src_pc;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::op_jal: begin
        ctrl.src_a     = rv_pkg::src_pc;
        ctrl.imm       = imm_j;
        ctrl.wb_src    = rv_pkg::wb_pc4;
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
      end
      rv_pkg::op_jalr: begin
        ctrl.wb_src    = rv_pkg::wb_pc4;
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
      end
      rv_pkg::op_load: begin
        ctrl.wb_src    = rv_pkg::wb_load;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
      end
      rv_pkg::op_store: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
      end
      default: begin
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire           clk,
  input  rv_pkg::ctrl_t ctrl,
  input  wire           retire,
  input  rv_pkg::word_t wdata,
  output rv_pkg::word_t rs1_data,
  output rv_pkg::word_t rs2_data
);

  rv_pkg::word_t regs [32];

  logic write_en;

  // commit only once the instruction actually retires
  assign write_en = retire && ctrl.reg_write && (ctrl.rd != '0);

  always_ff @(posedge clk) begin
    if (write_en) begin
      regs[ctrl.rd] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
  assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t sum,
  output rv_pkg::word_t wdata
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t pc_seq;

  // one adder serves addresses, jump targets and addi
  assign op_a = (ctrl.src_a == rv_pkg::src_pc) ? pc : rs1_data;
  assign sum  = op_a + ctrl.imm;

  assign pc_seq = pc + 32'd4;  // link value for jal and jalr

  always_comb begin
    case (ctrl.wb_src)
      rv_pkg::wb_pc4:  wdata = pc_seq;
      rv_pkg::wb_load: wdata = load_data;
      default:         wdata = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire             clk,
  input  wire             reset,
  input  rv_pkg::ctrl_t   ctrl,
  input  rv_pkg::word_t   sum,
  input  rv_pkg::word_t   rs2_data,
  output rv_pkg::wb_req_t wb_req,
  input  rv_pkg::wb_rsp_t wb_rsp,
  output rv_pkg::word_t   load_data,
  output logic            retire
);

  rv_pkg::lsu_state_e state;

  logic              mem_op;
  logic              we_q;
  rv_pkg::word_t     adr_q;
  rv_pkg::word_t     dat_q;
  rv_pkg::byte_sel_t sel_q;
  rv_pkg::byte_sel_t sel_next;
  rv_pkg::word_t     dat_next;
  logic [7:0]        load_byte;
  logic [15:0]       load_half;

  assign mem_op = ctrl.mem_read || ctrl.mem_write;

  // lane select from width and low address bits, natural alignment assumed
  always_comb begin
    case (ctrl.funct3[1:0])
      2'b00: begin
        sel_next = 4'b0001 << sum[1:0];
        dat_next = {4{rs2_data[7:0]}};
      end
      2'b01: begin
        sel_next = sum[1] ? 4'b1100 : 4'b0011;
        dat_next = {2{rs2_data[15:0]}};
      end
      default: begin
        sel_next = 4'b1111;
        dat_next = rs2_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::lsu_idle;
      we_q  <= 1'b0;
    end else begin
      case (state)
        rv_pkg::lsu_idle: begin
          if (mem_op) begin
            state <= rv_pkg::lsu_bus;
            we_q  <= ctrl.mem_write;
          end
        end
        default: begin
          if (wb_rsp.ack) begin  // cycle ends, drop cyc and stb next cycle
            state <= rv_pkg::lsu_idle;
            we_q  <= 1'b0;
          end
        end
      endcase
    end
  end

  // request payload held stable for the whole access
  always_ff @(posedge clk) begin
    if (state == rv_pkg::lsu_idle && mem_op) begin
      adr_q <= {sum[31:2], 2'b00};
      dat_q <= dat_next;
      sel_q <= sel_next;
    end
  end

  assign wb_req.cyc = (state == rv_pkg::lsu_bus);
  assign wb_req.stb = (state == rv_pkg::lsu_bus);
  assign wb_req.we  = we_q;
  assign wb_req.adr = adr_q;
  assign wb_req.dat = dat_q;
  assign wb_req.sel = sel_q;

  // pick the addressed lane out of the returned word
  always_comb begin
    case (sum[1:0])
      2'b01:   load_byte = wb_rsp.dat[15:8];
      2'b10:   load_byte = wb_rsp.dat[23:16];
      2'b11:   load_byte = wb_rsp.dat[31:24];
      default: load_byte = wb_rsp.dat[7:0];
    endcase
  end

  assign load_half = sum[1] ? wb_rsp.dat[31:16] : wb_rsp.dat[15:0];

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{load_byte[7]}}, load_byte};   // lb
      3'b001:  load_data = {{16{load_half[15]}}, load_half};  // lh
      3'b100:  load_data = {24'h000000, load_byte};           // lbu
      3'b101:  load_data = {16'h0000, load_half};             // lhu
      default: load_data = wb_rsp.dat;
    endcase
  end

  // non-memory ops retire at once, memory ops on ack
  always_comb begin
    if (reset) begin
      retire = 1'b0;
    end else if (state == rv_pkg::lsu_idle) begin
      retire = !mem_op;
    end else begin
      retire = wb_rsp.ack;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  wire           clk,
  input  wire           reset,
  input  rv_pkg::ctrl_t ctrl,
  input  wire           retire,
  input  rv_pkg::word_t sum,
  output rv_pkg::word_t pc
);

  rv_pkg::word_t pc_next;

  // jalr target has bit 0 cleared, jal target is even already
  assign pc_next = ctrl.jump ? {sum[31:1], 1'b0} : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (retire) begin  // held while a bus access waits
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  wire             clk,
  input  wire             reset,
  input  rv_pkg::word_t   inst,    // instruction at pc
  output rv_pkg::word_t   pc,
  output logic            retire,
  output rv_pkg::wb_req_t wb_req,  // data port
  input  rv_pkg::wb_rsp_t wb_rsp
);

  rv_pkg::ctrl_t ctrl;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t sum;
  rv_pkg::word_t wdata;
  rv_pkg::word_t load_data;

  rv_decoder i_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .ctrl     (ctrl),
    .retire   (retire),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_execute (
    .ctrl      (ctrl),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .load_data (load_data),
    .sum       (sum),
    .wdata     (wdata)
  );

  rv_lsu i_lsu (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .sum       (sum),
    .rs2_data  (rs2_data),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .load_data (load_data),
    .retire    (retire)
  );

  rv_pc_unit #(
    .RESET_PC (RESET_PC)
  ) i_pc_unit (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl),
    .retire (retire),
    .sum    (sum),
    .pc     (pc)
  );

endmodule

`default_nettype wire

// ==== tests/rv_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_checker #(
  parameter rv_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  wire             clk,
  input  wire             reset,
  input  rv_pkg::word_t   inst,
  input  rv_pkg::word_t   pc,
  input  wire             retire,
  input  rv_pkg::wb_req_t wb_req,
  input  rv_pkg::wb_rsp_t wb_rsp,
  output int              errors,
  output int              checks
);

  rv_pkg::word_t   regs [32];
  rv_pkg::word_t   mem [64];  // model copy of the slave memory
  rv_pkg::word_t   mpc;
  rv_pkg::wb_req_t req_q;
  logic            stall_q;
  logic            is_mem;

  initial begin
    errors = 0;
    checks = 0;
    for (int i = 0; i < 64; i++) mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic problem(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  function automatic logic [3:0] lane_sel(input logic [1:0] width, input logic [1:0] low);
    case (width)
      2'b00:   return 4'b0001 << low;
      2'b01:   return low[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic step_model();
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [2:0]    f3;
    logic          has_wr;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t addr;
    rv_pkg::word_t lane;
    rv_pkg::word_t wr;
    rv_pkg::word_t sdat;
    rv_pkg::word_t next_pc;
    logic [3:0]    sel;
    rd = inst[11:7];
    rs1 = inst[19:15];
    f3 = inst[14:12];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    next_pc = mpc + 32'd4;
    has_wr = 1'b1;
    wr = '0;
    case (inst[6:0])
      7'b0010011: begin
        wr = regs[rs1] + imm_i;
        has_wr = (f3 == 3'b000);
      end
      7'b0110111: wr = {inst[31:12], 12'h000};
      7'b0010111: wr = mpc + {inst[31:12], 12'h000};
      7'b1101111: begin
        wr = mpc + 32'd4;
        next_pc = mpc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'b1100111: begin
        wr = mpc + 32'd4;
        next_pc = (regs[rs1] + imm_i) & ~32'h1;
      end
      7'b0000011: begin
        addr = regs[rs1] + imm_i;
        sel = lane_sel(f3[1:0], addr[1:0]);
        compare("wb_req.adr", {addr[31:2], 2'b00}, wb_req.adr);
        compare("wb_req.we", 32'h0, {31'h0, wb_req.we});
        compare("wb_req.sel", {28'h0, sel}, {28'h0, wb_req.sel});
        lane = mem[addr[7:2]] >> (8 * addr[1:0]);
        case (f3)
          3'b000:  wr = {{24{lane[7]}}, lane[7:0]};
          3'b001:  wr = {{16{lane[15]}}, lane[15:0]};
          3'b100:  wr = {24'h0, lane[7:0]};
          3'b101:  wr = {16'h0, lane[15:0]};
          default: wr = lane;
        endcase
      end
      7'b0100011: begin
        has_wr = 1'b0;
        addr = regs[rs1] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        sel = lane_sel(f3[1:0], addr[1:0]);
        sdat = regs[inst[24:20]];
        if (f3[1:0] == 2'b00) sdat = {4{sdat[7:0]}};
        else if (f3[1:0] == 2'b01) sdat = {2{sdat[15:0]}};
        compare("wb_req.adr", {addr[31:2], 2'b00}, wb_req.adr);
        compare("wb_req.we", 32'h1, {31'h0, wb_req.we});
        compare("wb_req.sel", {28'h0, sel}, {28'h0, wb_req.sel});
        compare("wb_req.dat", sdat, wb_req.dat);
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) mem[addr[7:2]][8*b +: 8] = sdat[8*b +: 8];
        end
      end
      default: has_wr = 1'b0;  // unknown opcode only advances pc
    endcase
    if (has_wr && rd != 5'd0) regs[rd] = wr;
    mpc = next_pc;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      mpc = RESET_PC;
      stall_q = 1'b0;
      for (int i = 0; i < 32; i++) regs[i] = '0;
    end else begin
      is_mem = (inst[6:0] == 7'b0000011) || (inst[6:0] == 7'b0100011);
      compare("pc", mpc, pc);  // also holds pc steady during a bus wait
      if (stall_q) begin
        compare("wb_req.adr", req_q.adr, wb_req.adr);
        compare("wb_req.dat", req_q.dat, wb_req.dat);
        compare("wb_req.sel", {28'h0, req_q.sel}, {28'h0, wb_req.sel});
        compare("wb_req.we", {31'h0, req_q.we}, {31'h0, wb_req.we});
      end
      if (!is_mem && !retire) problem("non-memory instruction did not retire");
      if (!is_mem && (wb_req.cyc || wb_req.stb)) problem("bus cycle without a memory op");
      if (is_mem && retire && !wb_rsp.ack) problem("memory op retired before ack");
      stall_q = wb_req.stb && !wb_rsp.ack;
      req_q = wb_req;
      if (retire) step_model();
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core_top;

  localparam rv_pkg::word_t RESET_PC = 32'h8000_0000;
  localparam int NUM_RANDOM = 2000;
  localparam int RETIRE_LIMIT = 20;  // enough cycles for 3 wait states

  logic            clk;
  logic            reset;
  rv_pkg::word_t   inst;
  rv_pkg::word_t   pc;
  logic            retire;
  rv_pkg::wb_req_t wb_req;
  rv_pkg::wb_rsp_t wb_rsp;
  logic            retired_q;
  logic [15:0]     gen_lfsr;
  logic [15:0]     bus_lfsr;
  rv_pkg::word_t   mem [64];
  logic            busy;
  logic [1:0]      wait_cnt;
  int              errors;
  int              checks;
  int              errors_before;
  rv_pkg::word_t   next_inst;
  logic [31:0]     init_imm;

  rv_core_top #(.RESET_PC(RESET_PC)) i_dut (
    .clk    (clk),
    .reset  (reset),
    .inst   (inst),
    .pc     (pc),
    .retire (retire),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  rv_checker #(.RESET_PC(RESET_PC)) i_checker (
    .clk    (clk),
    .reset  (reset),
    .inst   (inst),
    .pc     (pc),
    .retire (retire),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .errors (errors),
    .checks (checks)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic gen_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      gen_lfsr = lfsr_step(gen_lfsr);
      v = {v[30:0], gen_lfsr[0]};
    end
  endtask

  function automatic logic [7:0] align_offset(input logic [7:0] off, input logic [1:0] width);
    case (width)
      2'b00:   return off;
      2'b01:   return {off[7:1], 1'b0};
      default: return {off[7:2], 2'b00};
    endcase
  endfunction

  task automatic make_inst(output rv_pkg::word_t ins);
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs;
    logic [31:0] imm;
    logic [31:0] f3;
    logic [31:0] sgn;
    logic [20:0] j;
    logic [7:0]  off;
    gen_bits(3, kind);
    gen_bits(3, rd);
    gen_bits(3, rs);
    gen_bits(20, imm);
    gen_bits(3, f3);
    gen_bits(1, sgn);
    case (kind[2:0])
      3'd1: ins = {imm[19:0], 2'b00, rd[2:0], 7'b0110111};  // lui
      3'd2: ins = {imm[19:0], 2'b00, rd[2:0], 7'b0010111};  // auipc
      3'd3: begin
        j = {11'd0, imm[7:0], 2'b00};
        if (j == '0) j = 21'd4;  // never jump to itself
        if (sgn[0]) j = -j;
        ins = {j[20], j[10:1], j[11], j[19:12], 2'b00, rd[2:0], 7'b1101111};
      end
      3'd4: ins = {imm[11:0], 5'd0, 3'b000, 2'b00, rd[2:0], 7'b1100111};  // jalr off x0
      3'd5: begin
        if (f3[2:0] == 3'd3 || f3[2:1] == 2'b11) f3 = 32'd2;
        off = align_offset(imm[7:0], f3[1:0]);
        ins = {4'h0, off, 5'd0, f3[2:0], 2'b00, rd[2:0], 7'b0000011};
      end
      3'd6: begin
        if (f3[1:0] == 2'b11) f3 = 32'd2;
        f3[2] = 1'b0;
        off = align_offset(imm[7:0], f3[1:0]);
        ins = {4'h0, off[7:5], 2'b00, rs[2:0], 5'd0, f3[2:0], off[4:0], 7'b0100011};
      end
      default: ins = {imm[11:0], 2'b00, rs[2:0], 3'b000, 2'b00, rd[2:0], 7'b0010011};  // addi
    endcase
  endtask

  // present one instruction and wait for its retire
  task automatic run_inst(input rv_pkg::word_t ins);
    int cycles;
    inst = ins;
    cycles = 0;
    @(negedge clk);
    while (!retired_q && cycles < RETIRE_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    if (!retired_q) begin
      $display("timeout: instruction %h at pc %h never retired", ins, pc);
      $display("Done: errors found");
      $finish;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // wishbone slave with 0 to 3 wait states per access
  always @(negedge clk) begin
    if (reset || wb_rsp.ack) begin
      wb_rsp.ack = 1'b0;
      busy = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!busy) begin
        busy = 1'b1;
        bus_lfsr = lfsr_step(bus_lfsr);
        wait_cnt[0] = bus_lfsr[0];
        bus_lfsr = lfsr_step(bus_lfsr);
        wait_cnt[1] = bus_lfsr[0];
      end
      if (wait_cnt == 2'd0) begin
        wb_rsp.ack = 1'b1;
        wb_rsp.dat = mem[wb_req.adr[7:2]];
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    retired_q <= retire;
    if (wb_rsp.ack && wb_req.stb && wb_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_req.sel[b]) mem[wb_req.adr[7:2]][8*b +: 8] <= wb_req.dat[8*b +: 8];
      end
    end
  end

  initial begin
    gen_lfsr = 16'd33;
    bus_lfsr = 16'd33;
    reset = 1'b1;
    inst = 32'h0000_0013;  // nop
    wb_rsp = '0;
    busy = 1'b0;
    wait_cnt = 2'd0;
    for (int i = 0; i < 64; i++) mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    errors_before = errors;
    for (int r = 1; r < 8; r++) begin  // give x1..x7 known values
      gen_bits(12, init_imm);
      run_inst({init_imm[11:0], 5'd0, 3'b000, r[4:0], 7'b0010011});
    end
    $display("test init_regs finished, %0d errors", errors - errors_before);

    errors_before = errors;
    repeat (NUM_RANDOM) begin
      make_inst(next_inst);
      run_inst(next_inst);
    end
    $display("test random_run finished, %0d errors", errors - errors_before);

    $display("summary: 2 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core_top.f ====
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_pc_unit.sv
hw/rv_core_top.sv
tests/rv_checker.sv
tests/tb_rv_core_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, status follows the result line
cd "$(dirname "$0")" &&
verilator --binary --timing -f rv_core_top.f --top-module tb_rv_core_top -o sim_tb &&
./obj_dir/sim_tb | grep -F "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
